// ==== src.f ====
logic/pps_time_pkg.sv
logic/pps_reg_pkg.sv
logic/internal_pps.sv
logic/pps_source_select.sv
logic/pps_timekeeper.sv
logic/pps_time_regs.sv
logic/pps_time_top.sv
tests/tb_pps_time.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_pps_time -o sim_tb

run: compile
	-./obj_dir/sim_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "run failed"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/tb_pps_time.sv ====
`default_nettype none

module tb_pps_time;

    localparam int CLK_PER_SEC   = 200;
    localparam int HOLDOFF_SHIFT = 2;
    // registers, four trims of three flags, two loads, five external pairs, margin
    localparam int CYCLE_LIMIT = 800 + 4 * 3 * 230 + 2 * 3 * 230 + 5 * 120 + 1000;

    logic                   sys_clk_i = 1'b0;
    logic                   runrst_i;
    logic                   pps_i;
    logic                   reg_wr_i;
    logic                   reg_rd_i;
    pps_reg_pkg::reg_addr_t reg_addr_i;
    pps_reg_pkg::reg_data_t reg_wdata_i;
    pps_reg_pkg::reg_data_t reg_rdata_o;
    logic                   reg_rack_o;
    logic                   pps_flag_o;
    pps_time_pkg::sec_t     cur_sec_o;
    pps_time_pkg::cyc_t     cur_time_o;
    pps_time_pkg::cyc_t     last_pps_o;
    pps_time_pkg::cyc_t     llast_pps_o;

    // reference model state
    logic                   m_en;
    logic                   m_ext;
    pps_time_pkg::holdoff_t m_hold;
    pps_time_pkg::trim_t    m_trim_next;
    pps_time_pkg::trim_t    m_trim_act;
    logic                   m_upd;
    pps_time_pkg::sec_t     m_sec_val;
    logic                   m_load;
    int                     m_phase;
    logic                   m_int;
    logic                   m_pps_q;
    int                     m_edge;
    int                     m_due;
    int                     m_last_ext;
    logic                   m_flag;
    pps_time_pkg::sec_t     m_sec;
    pps_time_pkg::cyc_t     m_time;
    pps_time_pkg::cyc_t     m_last;
    pps_time_pkg::cyc_t     m_llast;
    logic                   m_rack;
    pps_reg_pkg::reg_data_t m_rdata;
    int                     period;
    int                     hold_span;
    logic                   ext_hit;

    logic [31:0] lfsr_state = 32'd31;
    int          cycle_count = 0;
    int          flag_count = 0;

    pps_time_top #(
        .CLK_PER_SEC  (CLK_PER_SEC),
        .HOLDOFF_SHIFT(HOLDOFF_SHIFT)
    ) u_dut (
        .sys_clk_i  (sys_clk_i),
        .runrst_i   (runrst_i),
        .pps_i      (pps_i),
        .reg_wr_i   (reg_wr_i),
        .reg_rd_i   (reg_rd_i),
        .reg_addr_i (reg_addr_i),
        .reg_wdata_i(reg_wdata_i),
        .reg_rdata_o(reg_rdata_o),
        .reg_rack_o (reg_rack_o),
        .pps_flag_o (pps_flag_o),
        .cur_sec_o  (cur_sec_o),
        .cur_time_o (cur_time_o),
        .last_pps_o (last_pps_o),
        .llast_pps_o(llast_pps_o)
    );

    always #10 sys_clk_i = ~sys_clk_i;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int rand_trim();
        return int'(rand_bits(6) % 41) - 20;
    endfunction

    task automatic check_sec(input string name, input pps_time_pkg::sec_t got,
                             input pps_time_pkg::sec_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_cyc(input string name, input pps_time_pkg::cyc_t got,
                             input pps_time_pkg::cyc_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_data(input string name, input pps_reg_pkg::reg_data_t got,
                              input pps_reg_pkg::reg_data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input bit exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic pps_reg_pkg::reg_data_t model_readback(input pps_reg_pkg::reg_addr_t a);
        case (a)
            pps_reg_pkg::ADDR_CTRL:      return {30'd0, m_ext, m_en};
            pps_reg_pkg::ADDR_HOLDOFF:   return {16'd0, m_hold};
            pps_reg_pkg::ADDR_TRIM:      return {16'd0, m_trim_act};
            pps_reg_pkg::ADDR_CUR_SEC:   return m_sec;
            pps_reg_pkg::ADDR_LAST_PPS:  return m_last;
            pps_reg_pkg::ADDR_LLAST_PPS: return m_llast;
            default:                     return '0;
        endcase
    endfunction

    // cycle model, sees the inputs the DUT samples on the same edge
    always @(posedge sys_clk_i) begin
        if (runrst_i) begin
            m_en <= 1'b0;
            m_ext <= 1'b0;
            m_hold <= 16'd1;
            m_trim_next <= '0;
            m_trim_act <= '0;
            m_upd <= 1'b0;
            m_sec_val <= '0;
            m_load <= 1'b0;
            m_phase <= 0;
            m_int <= 1'b0;
            m_pps_q <= 1'b0;
            m_edge <= 0;
            m_due <= -1;
            m_last_ext <= -1000000;
            m_flag <= 1'b0;
            m_sec <= '0;
            m_time <= '0;
            m_last <= '0;
            m_llast <= '0;
            m_rack <= 1'b0;
            m_rdata <= '0;
        end else begin
            m_edge <= m_edge + 1;
            m_time <= m_time + 32'd1;
            if (reg_wr_i) begin
                case (reg_addr_i)
                    pps_reg_pkg::ADDR_CTRL: begin
                        m_en  <= reg_wdata_i[0];
                        m_ext <= reg_wdata_i[1];
                    end
                    pps_reg_pkg::ADDR_HOLDOFF:  m_hold <= reg_wdata_i[15:0];
                    pps_reg_pkg::ADDR_TRIM:     m_trim_next <= reg_wdata_i[15:0];
                    pps_reg_pkg::ADDR_SEC_LOAD: m_sec_val <= reg_wdata_i;
                    default: ;
                endcase
            end
            m_upd  <= reg_wr_i && (reg_addr_i == pps_reg_pkg::ADDR_TRIM);
            m_load <= reg_wr_i && (reg_addr_i == pps_reg_pkg::ADDR_SEC_LOAD);
            if (m_upd) begin
                m_trim_act <= m_trim_next;
            end

            // internal pulse every CLK_PER_SEC plus trim cycles
            period = CLK_PER_SEC + int'(m_trim_act);
            if (!m_en) begin
                m_phase <= 0;
                m_int   <= 1'b0;
            end else if (m_phase >= period - 1) begin
                m_phase <= 0;
                m_int   <= 1'b1;
            end else begin
                m_phase <= m_phase + 1;
                m_int   <= 1'b0;
            end

            // external flag two edges after the sampled rise, masked by holdoff
            m_pps_q <= pps_i;
            if (pps_i && !m_pps_q) begin
                m_due <= m_edge + 2;
            end
            hold_span = (int'(m_hold) << HOLDOFF_SHIFT) + (1 << HOLDOFF_SHIFT) - 1 + 2;
            ext_hit = m_ext && (m_due == m_edge) && (m_edge - m_last_ext > hold_span);
            if (!m_ext) begin
                m_last_ext <= -1000000;
            end else if (ext_hit) begin
                m_last_ext <= m_edge;
            end
            m_flag <= m_ext ? ext_hit : m_int;

            if (m_load) begin
                m_sec <= m_sec_val;
            end else if (m_flag) begin
                m_sec <= m_sec + 32'd1;
            end
            if (m_flag) begin
                m_last  <= m_time;
                m_llast <= m_last;
            end

            m_rack <= reg_rd_i;
            if (reg_rd_i) begin
                m_rdata <= model_readback(reg_addr_i);
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge sys_clk_i) begin
        if (!runrst_i) begin
            check_flag("pps_flag_o", pps_flag_o, m_flag);
            check_sec("cur_sec_o", cur_sec_o, m_sec);
            check_cyc("cur_time_o", cur_time_o, m_time);
            check_cyc("last_pps_o", last_pps_o, m_last);
            check_cyc("llast_pps_o", llast_pps_o, m_llast);
            check_flag("reg_rack_o", reg_rack_o, m_rack);
            if (m_rack) begin
                check_data("reg_rdata_o", reg_rdata_o, m_rdata);
            end
            if (pps_flag_o) begin
                flag_count++;
            end
        end
    end

    always @(posedge sys_clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sys_clk_i);
    endtask

    task automatic write_reg(input pps_reg_pkg::reg_addr_t a, input pps_reg_pkg::reg_data_t d);
        @(posedge sys_clk_i);
        reg_wr_i    <= 1'b1;
        reg_addr_i  <= a;
        reg_wdata_i <= d;
        @(posedge sys_clk_i);
        reg_wr_i <= 1'b0;
    endtask

    task automatic read_reg(input pps_reg_pkg::reg_addr_t a);
        @(posedge sys_clk_i);
        reg_rd_i   <= 1'b1;
        reg_addr_i <= a;
        @(posedge sys_clk_i);
        reg_rd_i <= 1'b0;
    endtask

    task automatic wait_flags(input int n);
        repeat (n) begin
            @(negedge sys_clk_i);
            while (!pps_flag_o) @(negedge sys_clk_i);
        end
    endtask

    task automatic ext_pulse();
        @(posedge sys_clk_i);
        pps_i <= 1'b1;
        repeat (3) @(posedge sys_clk_i);
        pps_i <= 1'b0;
    endtask

    task automatic run_register_test();
        pps_reg_pkg::reg_data_t d;
        for (int a = 0; a < 8; a++) begin
            read_reg(pps_reg_pkg::reg_addr_t'(a));
        end
        for (int k = 0; k < 8; k++) begin
            d = rand_bits(32);
            write_reg(pps_reg_pkg::ADDR_CTRL, d & 32'h3);
            read_reg(pps_reg_pkg::ADDR_CTRL);
            write_reg(pps_reg_pkg::ADDR_HOLDOFF, {16'd0, d[31:16]});
            read_reg(pps_reg_pkg::ADDR_HOLDOFF);
            write_reg(pps_reg_pkg::ADDR_TRIM, {16'd0, 16'(rand_trim())});
            read_reg(pps_reg_pkg::ADDR_TRIM);
            read_reg(pps_reg_pkg::ADDR_SEC_LOAD);
            read_reg(3'd7);
        end
    endtask

    task automatic run_internal_test();
        int t;
        write_reg(pps_reg_pkg::ADDR_CTRL, 32'd1);
        for (int k = 0; k < 4; k++) begin
            t = rand_trim();
            write_reg(pps_reg_pkg::ADDR_TRIM, {16'd0, 16'(t)});
            wait_flags(3);
            check_cyc("pps interval", last_pps_o - llast_pps_o,
                      pps_time_pkg::cyc_t'(CLK_PER_SEC + t));
            read_reg(pps_reg_pkg::ADDR_TRIM);
        end
    endtask

    task automatic run_second_test();
        for (int k = 0; k < 2; k++) begin
            write_reg(pps_reg_pkg::ADDR_SEC_LOAD, rand_bits(32));
            read_reg(pps_reg_pkg::ADDR_CUR_SEC);
            wait_flags(2);
            read_reg(pps_reg_pkg::ADDR_CUR_SEC);
            read_reg(pps_reg_pkg::ADDR_LAST_PPS);
            read_reg(pps_reg_pkg::ADDR_LLAST_PPS);
        end
    endtask

    task automatic run_external_test();
        int h;
        int span;
        int start_count;
        h = 4 + int'(rand_bits(3));
        span = (h << HOLDOFF_SHIFT) + (1 << HOLDOFF_SHIFT) - 1;
        write_reg(pps_reg_pkg::ADDR_HOLDOFF, pps_reg_pkg::reg_data_t'(h));
        // internal PPS stays enabled and must be ignored
        write_reg(pps_reg_pkg::ADDR_CTRL, 32'd3);
        start_count = flag_count;
        for (int k = 0; k < 5; k++) begin
            wait_cycles(span + 8 + int'(rand_bits(4)));
            ext_pulse();
            // second pulse lands well inside the holdoff
            wait_cycles(2 + int'(rand_bits(2)));
            ext_pulse();
        end
        wait_cycles(span + 10);
        check_data("external flag count", pps_reg_pkg::reg_data_t'(flag_count - start_count),
                   32'd5);
        read_reg(pps_reg_pkg::ADDR_LAST_PPS);
        read_reg(pps_reg_pkg::ADDR_LLAST_PPS);
    endtask

    initial begin
        runrst_i    = 1'b1;
        pps_i       = 1'b0;
        reg_wr_i    = 1'b0;
        reg_rd_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        repeat (10) @(posedge sys_clk_i);
        runrst_i <= 1'b0;
        run_register_test();
        run_internal_test();
        run_second_test();
        run_external_test();
        wait_cycles(10);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/pps_time_top.sv ====
`default_nettype none

// PPS time subsystem, all on sys_clk_i
module pps_time_top #(
    parameter int CLK_PER_SEC   = 100000000,
    parameter int HOLDOFF_SHIFT = 12
) (
    input  wire logic                   sys_clk_i,
    input  wire logic                   runrst_i,
    input  wire logic                   pps_i,
    input  wire logic                   reg_wr_i,
    input  wire logic                   reg_rd_i,
    input  wire pps_reg_pkg::reg_addr_t reg_addr_i,
    input  wire pps_reg_pkg::reg_data_t reg_wdata_i,
    output pps_reg_pkg::reg_data_t      reg_rdata_o,
    output logic                        reg_rack_o,
    output logic                        pps_flag_o,
    output pps_time_pkg::sec_t          cur_sec_o,
    output pps_time_pkg::cyc_t          cur_time_o,
    output pps_time_pkg::cyc_t          last_pps_o,
    output pps_time_pkg::cyc_t          llast_pps_o
);

    logic                   en_int_pps;
    logic                   use_ext_pps;
    pps_time_pkg::holdoff_t pps_holdoff;
    // trim written by software, and the one the generator runs with
    pps_time_pkg::trim_t    trim_next;
    pps_time_pkg::trim_t    trim_active;
    logic                   update_trim;
    pps_time_pkg::sec_t     sec_load_val;
    logic                   load_sec;
    logic                   int_pps;

    internal_pps #(
        .CLK_PER_SEC(CLK_PER_SEC)
    ) u_intpps (
        .sys_clk_i    (sys_clk_i),
        .runrst_i     (runrst_i),
        .en_i         (en_int_pps),
        .trim_i       (trim_next),
        .update_trim_i(update_trim),
        .trim_o       (trim_active),
        .pps_o        (int_pps)
    );

    pps_source_select #(
        .HOLDOFF_SHIFT(HOLDOFF_SHIFT)
    ) u_sel (
        .sys_clk_i (sys_clk_i),
        .runrst_i  (runrst_i),
        .pps_i     (pps_i),
        .int_pps_i (int_pps),
        .use_ext_i (use_ext_pps),
        .holdoff_i (pps_holdoff),
        .pps_flag_o(pps_flag_o)
    );

    pps_timekeeper u_tk (
        .sys_clk_i  (sys_clk_i),
        .runrst_i   (runrst_i),
        .pps_flag_i (pps_flag_o),
        .load_sec_i (load_sec),
        .sec_i      (sec_load_val),
        .cur_sec_o  (cur_sec_o),
        .cur_time_o (cur_time_o),
        .last_pps_o (last_pps_o),
        .llast_pps_o(llast_pps_o)
    );

    pps_time_regs u_regs (
        .sys_clk_i    (sys_clk_i),
        .runrst_i     (runrst_i),
        .reg_wr_i     (reg_wr_i),
        .reg_rd_i     (reg_rd_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .trim_i       (trim_active),
        .cur_sec_i    (cur_sec_o),
        .last_pps_i   (last_pps_o),
        .llast_pps_i  (llast_pps_o),
        .reg_rdata_o  (reg_rdata_o),
        .reg_rack_o   (reg_rack_o),
        .en_int_pps_o (en_int_pps),
        .use_ext_pps_o(use_ext_pps),
        .holdoff_o    (pps_holdoff),
        .trim_o       (trim_next),
        .update_trim_o(update_trim),
        .sec_o        (sec_load_val),
        .load_sec_o   (load_sec)
    );

endmodule

`default_nettype wire

// ==== logic/pps_time_regs.sv ====
`default_nettype none

// software registers for the time block on a plain strobe bus
module pps_time_regs (
    input  wire logic                    sys_clk_i,
    input  wire logic                    runrst_i,
    input  wire logic                    reg_wr_i,
    input  wire logic                    reg_rd_i,
    input  wire pps_reg_pkg::reg_addr_t  reg_addr_i,
    input  wire pps_reg_pkg::reg_data_t  reg_wdata_i,
    input  wire pps_time_pkg::trim_t     trim_i,
    input  wire pps_time_pkg::sec_t      cur_sec_i,
    input  wire pps_time_pkg::cyc_t      last_pps_i,
    input  wire pps_time_pkg::cyc_t      llast_pps_i,
    output pps_reg_pkg::reg_data_t       reg_rdata_o,
    output logic                         reg_rack_o,
    output logic                         en_int_pps_o,
    output logic                         use_ext_pps_o,
    output pps_time_pkg::holdoff_t       holdoff_o,
    output pps_time_pkg::trim_t          trim_o,
    output logic                         update_trim_o,
    output pps_time_pkg::sec_t           sec_o,
    output logic                         load_sec_o
);

    logic                   wr_ctrl;
    logic                   wr_holdoff;
    logic                   wr_trim;
    logic                   wr_sec;
    pps_reg_pkg::reg_data_t rd_mux;

    assign wr_ctrl    = reg_wr_i && (reg_addr_i == pps_reg_pkg::ADDR_CTRL);
    assign wr_holdoff = reg_wr_i && (reg_addr_i == pps_reg_pkg::ADDR_HOLDOFF);
    assign wr_trim    = reg_wr_i && (reg_addr_i == pps_reg_pkg::ADDR_TRIM);
    assign wr_sec     = reg_wr_i && (reg_addr_i == pps_reg_pkg::ADDR_SEC_LOAD);

    // control bits and holdoff
    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            en_int_pps_o  <= 1'b0;
            use_ext_pps_o <= 1'b0;
            holdoff_o     <= pps_time_pkg::HOLDOFF_RESET;
        end else begin
            if (wr_ctrl) begin
                en_int_pps_o  <= reg_wdata_i[0];
                use_ext_pps_o <= reg_wdata_i[1];
            end
            if (wr_holdoff) begin
                holdoff_o <= reg_wdata_i[15:0];
            end
        end
    end

    // trim and second values written by software
    always_ff @(posedge sys_clk_i) begin
        if (wr_trim) begin
            trim_o <= pps_time_pkg::trim_t'(reg_wdata_i[15:0]);
        end
        if (wr_sec) begin
            sec_o <= reg_wdata_i;
        end
    end

    // strobes go out in the same cycle as the new values
    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            update_trim_o <= 1'b0;
            load_sec_o    <= 1'b0;
        end else begin
            update_trim_o <= wr_trim;
            load_sec_o    <= wr_sec;
        end
    end

    always_comb begin
        case (reg_addr_i)
            pps_reg_pkg::ADDR_CTRL:      rd_mux = {30'd0, use_ext_pps_o, en_int_pps_o};
            pps_reg_pkg::ADDR_HOLDOFF:   rd_mux = {16'd0, holdoff_o};
            // the trim actually in use, not the pending one
            pps_reg_pkg::ADDR_TRIM:      rd_mux = {16'd0, trim_i};
            pps_reg_pkg::ADDR_CUR_SEC:   rd_mux = cur_sec_i;
            pps_reg_pkg::ADDR_LAST_PPS:  rd_mux = last_pps_i;
            pps_reg_pkg::ADDR_LLAST_PPS: rd_mux = llast_pps_i;
            default:                     rd_mux = '0;
        endcase
    end

    // readback registered, ack one cycle after the read strobe
    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            reg_rdata_o <= '0;
            reg_rack_o  <= 1'b0;
        end else begin
            reg_rack_o <= reg_rd_i;
            if (reg_rd_i) begin
                reg_rdata_o <= rd_mux;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pps_timekeeper.sv ====
`default_nettype none

// second counter, cycle counter and the last two PPS stamps
module pps_timekeeper (
    input  wire logic               sys_clk_i,
    input  wire logic               runrst_i,
    input  wire logic               pps_flag_i,
    input  wire logic               load_sec_i,
    input  wire pps_time_pkg::sec_t sec_i,
    output pps_time_pkg::sec_t      cur_sec_o,
    output pps_time_pkg::cyc_t      cur_time_o,
    output pps_time_pkg::cyc_t      last_pps_o,
    output pps_time_pkg::cyc_t      llast_pps_o
);

    // seconds, a software load beats the PPS increment
    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            cur_sec_o <= '0;
        end else if (load_sec_i) begin
            cur_sec_o <= sec_i;
        end else if (pps_flag_i) begin
            cur_sec_o <= cur_sec_o + 32'd1;
        end
    end

    // free-running cycle count from the end of reset
    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            cur_time_o <= '0;
        end else begin
            cur_time_o <= cur_time_o + 32'd1;
        end
    end

    // two-deep history, the older stamp shifts down on each flag
    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            last_pps_o  <= '0;
            llast_pps_o <= '0;
        end else if (pps_flag_i) begin
            last_pps_o  <= cur_time_o;
            llast_pps_o <= last_pps_o;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pps_source_select.sv ====
`default_nettype none

// external PPS capture with holdoff, and the choice of PPS source
module pps_source_select #(
    parameter int HOLDOFF_SHIFT = 12
) (
    input  wire logic                   sys_clk_i,
    input  wire logic                   runrst_i,
    input  wire logic                   pps_i,
    input  wire logic                   int_pps_i,
    input  wire logic                   use_ext_i,
    input  wire pps_time_pkg::holdoff_t holdoff_i,
    output logic                        pps_flag_o
);

    localparam int HOLD_W = $bits(pps_time_pkg::holdoff_t) + HOLDOFF_SHIFT;

    // two stage synchronizer, [0] samples the pin
    logic [1:0]        pps_sync;
    // previous value of the second stage
    logic              pps_prev;
    logic              ext_edge;
    logic              in_holdoff;
    logic [HOLD_W-1:0] hold_cnt;
    logic [HOLD_W-1:0] hold_start;

    // holdoff setting in coarse units, low bits filled with ones
    assign hold_start = {holdoff_i, {HOLDOFF_SHIFT{1'b1}}};

    // rising edge on the synchronized pin, masked while in holdoff
    assign ext_edge = pps_sync[1] & ~pps_prev & ~in_holdoff;

    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            pps_sync   <= 2'b00;
            pps_prev   <= 1'b0;
            in_holdoff <= 1'b0;
            hold_cnt   <= '0;
            pps_flag_o <= 1'b0;
        end else begin
            pps_sync <= {pps_sync[0], pps_i};
            pps_prev <= pps_sync[1];

            // holdoff only means anything on the external path
            if (!use_ext_i) begin
                in_holdoff <= 1'b0;
            end else if (pps_flag_o) begin
                in_holdoff <= 1'b1;
            end else if (hold_cnt == '0) begin
                in_holdoff <= 1'b0;
            end

            // counter sits at the start value until a holdoff begins
            if (!in_holdoff) begin
                hold_cnt <= hold_start;
            end else begin
                hold_cnt <= hold_cnt - 1'b1;
            end

            // flag lands on the third edge counting the one that samples pps_i
            pps_flag_o <= use_ext_i ? ext_edge : int_pps_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/internal_pps.sv ====
`default_nettype none

// free-running PPS made from sysclk, with a trimmable period
module internal_pps #(
    parameter int CLK_PER_SEC = 100000000
) (
    input  wire logic                sys_clk_i,
    input  wire logic                runrst_i,
    input  wire logic                en_i,
    input  wire pps_time_pkg::trim_t trim_i,
    input  wire logic                update_trim_i,
    output pps_time_pkg::trim_t      trim_o,
    output logic                     pps_o
);

    pps_time_pkg::cyc_t phase_cnt;
    pps_time_pkg::cyc_t trim_ext;
    pps_time_pkg::cyc_t wrap_val;

    // trim is signed so the size cast sign-extends it
    assign trim_ext = pps_time_pkg::cyc_t'(trim_o);

    // last count of the period, one second plus trim minus one
    assign wrap_val = pps_time_pkg::cyc_t'(CLK_PER_SEC) + trim_ext - 32'd1;

    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            trim_o    <= '0;
            phase_cnt <= '0;
            pps_o     <= 1'b0;
        end else begin
            // new trim is adopted on the strobe only
            if (update_trim_i) begin
                trim_o <= trim_i;
            end

            if (!en_i) begin
                phase_cnt <= '0;
                pps_o     <= 1'b0;
            end else if (phase_cnt >= wrap_val) begin
                // >= so a shorter trim cannot strand the counter past the wrap
                phase_cnt <= '0;
                pps_o     <= 1'b1;
            end else begin
                phase_cnt <= phase_cnt + 32'd1;
                pps_o     <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pps_reg_pkg.sv ====
`default_nettype none

// register strobe bus widths and the address map of the time block
package pps_reg_pkg;

    typedef logic [2:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // bit 0 internal PPS enable, bit 1 external PPS select
    localparam reg_addr_t ADDR_CTRL      = 3'd0;
    localparam reg_addr_t ADDR_HOLDOFF   = 3'd1;
    // write sets the next trim, read gives the trim in use
    localparam reg_addr_t ADDR_TRIM      = 3'd2;
    // write only
    localparam reg_addr_t ADDR_SEC_LOAD  = 3'd3;
    localparam reg_addr_t ADDR_CUR_SEC   = 3'd4;
    localparam reg_addr_t ADDR_LAST_PPS  = 3'd5;
    localparam reg_addr_t ADDR_LLAST_PPS = 3'd6;

endpackage

`default_nettype wire

// ==== logic/pps_time_pkg.sv ====
`default_nettype none

// types for seconds, cycle stamps and the PPS tuning controls
package pps_time_pkg;

    // whole seconds since software last loaded the counter
    typedef logic [31:0] sec_t;

    // free-running sysclk cycle count, also used for PPS stamps
    typedef logic [31:0] cyc_t;

    // signed correction to the internal PPS period, in clocks
    typedef logic signed [15:0] trim_t;

    // external PPS holdoff, scaled up by HOLDOFF_SHIFT low bits
    typedef logic [15:0] holdoff_t;

    // smallest useful holdoff out of reset
    localparam holdoff_t HOLDOFF_RESET = 16'd1;

endpackage

`default_nettype wire
